/* axi_mem.f */
+incdir+common
common/axi_pkg.sv
common/mem_pkg.sv
axi_mem/axi_burst_addr.sv
axi_mem/axi_mem_rd.sv
axi_mem/axi_mem_wr.sv
source/mem_array.sv
source/axi_mem_top.sv
test/axi_mem_chk.sv
test/axi_mem_tb.sv

/* Bender.yml */
package:
  name: axi_mem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axi_pkg.sv
      - common/mem_pkg.sv
      - axi_mem/axi_burst_addr.sv
      - axi_mem/axi_mem_rd.sv
      - axi_mem/axi_mem_wr.sv
      - source/mem_array.sv
      - source/axi_mem_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/axi_mem_chk.sv
      - test/axi_mem_tb.sv

/* test/axi_mem_tb.sv */
`timescale 1ns/100ps

`include "axi_mem_cfg.svh"

module axi_mem_tb
  import axi_pkg::*;
;

  localparam int CLK_PERIOD  = 20;
  localparam int SEED        = 32'hcbf00285;
  localparam int TOTAL_BEATS = 97;  // 45 write beats, 52 read beats
  localparam int WDOG_CYCLES = TOTAL_BEATS * 20 + 500;

  logic    clk;
  logic    rstn;
  axi_ar_t ar;
  logic    ar_valid, ar_ready;
  axi_r_t  r;
  logic    r_valid, r_ready;
  axi_ar_t aw;
  logic    aw_valid, aw_ready;
  axi_w_t  w;
  logic    w_valid, w_ready;
  axi_b_t  b;
  logic    b_valid, b_ready;

  axi_data_t shadow [`MEM_DEPTH];  // Reference memory

  axi_mem_top axi_mem_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the DUT stopped answering before all tests were done");
    $display("CHECKS FAILED");
    $fatal(1);
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, act, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  function automatic int word_idx(input axi_addr_t addr);
    return (addr >> 3) % `MEM_DEPTH;
  endfunction

  function automatic axi_addr_t beat_addr(input axi_addr_t start, input axi_len_t len,
                                          input axi_size_t size, input axi_burst_e burst,
                                          input int k);
    axi_addr_t bytes;
    axi_addr_t block;
    axi_addr_t base;
    bytes = axi_addr_t'(1) << size;
    block = bytes * (axi_addr_t'(len) + 1);
    if (burst == BURST_INCR) return start + axi_addr_t'(k) * bytes;
    if (burst == BURST_WRAP && (len == 1 || len == 3 || len == 7 || len == 15)) begin
      base = start - (start % block);
      return base + ((start - base + axi_addr_t'(k) * bytes) % block);
    end
    return start;  // FIXED and illegal wrap lengths
  endfunction

  task automatic send_aw();
    aw_valid = 1'b1;
    @(negedge clk);
    while (!aw_ready) @(negedge clk);
    next_drive();
    aw_valid = 1'b0;
  endtask

  task automatic send_w();
    w_valid = 1'b1;
    @(negedge clk);
    while (!w_ready) @(negedge clk);
    next_drive();
    w_valid = 1'b0;
  endtask

  // Order 0 puts AW first, 1 puts W first, 2 sends both together
  task automatic do_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                          input int order, input int b_delay);
    aw = '{addr: addr, len: '0, size: 3'd3, burst: BURST_INCR};
    w  = '{data: data, strb: strb, last: 1'b1};
    if (order == 2) begin
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      @(negedge clk);
      while (!(aw_ready && w_ready)) @(negedge clk);
      next_drive();
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end else begin
      if (order == 0) send_aw();
      else send_w();
      repeat (2) begin
        @(negedge clk);
        check_eq(order == 0 ? aw_ready : w_ready, 0, "held channel ready");
        check_eq(b_valid, 0, "b_valid before pairing");
        next_drive();
      end
      if (order == 0) send_w();
      else send_aw();
    end
    repeat (b_delay) begin
      @(negedge clk);
      check_eq(b_valid, 1, "b_valid during stall");
      check_eq({aw_ready, w_ready}, 2'b00, "write readies during B stall");
      next_drive();
    end
    b_ready = 1'b1;
    @(negedge clk);
    check_eq(b_valid, 1, "b_valid");
    check_eq(b.resp, RESP_OKAY, "bresp");
    next_drive();
    b_ready = 1'b0;
    @(negedge clk);
    check_eq(b_valid, 0, "b_valid after B handshake");
    next_drive();
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) shadow[word_idx(addr)][i*8 +: 8] = data[i*8 +: 8];
    end
  endtask

  task automatic preload(input int first, input int count);
    for (int i = 0; i < count; i++) begin
      do_write(axi_addr_t'((first + i) * 8), {$urandom, $urandom}, 8'hff, 2, 0);
    end
  endtask

  task automatic do_read(input axi_addr_t start, input axi_len_t len, input axi_size_t size,
                         input axi_burst_e burst, input int stall_max);
    axi_data_t exp;
    int        stall;
    ar = '{addr: start, len: len, size: size, burst: burst};
    ar_valid = 1'b1;
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    next_drive();
    ar_valid = 1'b0;
    for (int k = 0; k <= len; k++) begin
      exp   = shadow[word_idx(beat_addr(start, len, size, burst, k))];
      stall = (stall_max > 0) ? $urandom % (stall_max + 1) : 0;
      repeat (stall) begin
        @(negedge clk);
        check_eq(r_valid, 1, "r_valid under back-pressure");
        check_eq(ar_ready, 0, "ar_ready under back-pressure");
        check_eq(r.data, exp, $sformatf("held data of beat %0d", k));
        next_drive();
      end
      r_ready = 1'b1;
      @(negedge clk);
      check_eq(r_valid, 1, $sformatf("r_valid of beat %0d", k));
      check_eq(ar_ready, 0, "ar_ready inside burst");
      check_eq(r.data, exp, $sformatf("data of beat %0d", k));
      check_eq(r.last, k == len, $sformatf("last of beat %0d", k));
      check_eq(r.resp, RESP_OKAY, "rresp");
      next_drive();
      r_ready = 1'b0;
    end
    @(negedge clk);
    check_eq(r_valid, 0, "r_valid after burst");
    check_eq(ar_ready, 1, "ar_ready after burst");
    next_drive();
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic test_reset_and_strobe();
    @(negedge clk);
    check_eq({ar_ready, aw_ready, w_ready}, 3'b111, "readies after reset");
    check_eq({r_valid, b_valid}, 2'b00, "valids after reset");
    next_drive();
    do_write(32'h40, {$urandom, $urandom}, 8'hff, 2, 0);
    do_write(32'h40, {$urandom, $urandom}, axi_strb_t'($urandom), 2, 0);
    do_read(32'h40, 8'd0, 3'd3, BURST_INCR, 0);
  endtask

  task automatic test_write_order();
    do_write(32'h80, {$urandom, $urandom}, 8'hff, 0, $urandom % 6 + 1);
    do_write(32'h88, {$urandom, $urandom}, 8'hff, 1, $urandom % 6 + 1);
    do_write(32'h90, {$urandom, $urandom}, 8'hff, 2, $urandom % 6 + 1);
    do_read(32'h80, 8'd2, 3'd3, BURST_INCR, 0);
  endtask

  task automatic test_incr();
    preload(32, 8);
    do_read(32'h100, 8'd7, 3'd3, BURST_INCR, 0);
  endtask

  task automatic test_wrap_fixed();
    preload(64, 8);
    do_read(32'h210, 8'd3, 3'd3, BURST_WRAP, 0);   // 32-byte block
    do_read(32'h228, 8'd7, 3'd3, BURST_WRAP, 0);   // 64-byte block
    do_read(32'h218, 8'd3, 3'd3, BURST_FIXED, 0);
  endtask

  task automatic test_stalls();
    preload(128, 24);
    do_read(32'h400, 8'd15, 3'd3, BURST_INCR, 3);
    do_read(32'h480, 8'd7, 3'd3, BURST_INCR, 2);
  endtask

  initial begin
    int seed_val;
    seed_val = $urandom(SEED);
    rstn     = 1'b1;  // Reset is active high
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rstn = 1'b0;
    test_reset_and_strobe();
    test_write_order();
    test_incr();
    test_wrap_fixed();
    test_stalls();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* test/axi_mem_chk.sv */
`timescale 1ns/100ps

module axi_mem_chk
  import axi_pkg::*;
(
  input logic    clk,
  input logic    rstn,
  input axi_ar_t ar,
  input logic    ar_valid,
  input logic    ar_ready,
  input axi_r_t  r,
  input logic    r_valid,
  input logic    r_ready,
  input axi_ar_t aw,
  input logic    aw_valid,
  input logic    aw_ready,
  input axi_w_t  w,
  input logic    w_valid,
  input logic    w_ready,
  input axi_b_t  b,
  input logic    b_valid,
  input logic    b_ready
);

  // ------------------------------------------------------------
  // Valid holds with a stable payload until ready
  // ------------------------------------------------------------

  a_ar_hold: assert property (@(posedge clk) disable iff (rstn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar)) else $error("AR dropped before ready");
  a_aw_hold: assert property (@(posedge clk) disable iff (rstn)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else $error("AW dropped before ready");
  a_w_hold: assert property (@(posedge clk) disable iff (rstn)
    w_valid && !w_ready |=> w_valid && $stable(w)) else $error("W dropped before ready");
  a_r_hold: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !r_ready |=> r_valid && $stable(r)) else $error("R dropped before ready");
  a_b_hold: assert property (@(posedge clk) disable iff (rstn)
    b_valid && !b_ready |=> b_valid && $stable(b)) else $error("B dropped before ready");

  // ------------------------------------------------------------
  // Read channel ordering
  // ------------------------------------------------------------

  a_last_fall: assert property (@(posedge clk) disable iff (rstn)
    $fell(r.last) |-> $fell(r_valid)) else $error("r.last fell inside a burst");
  a_no_ar_in_burst: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !(r_ready && r.last) |=> r_valid && !ar_ready)
    else $error("AR accepted during a burst");

endmodule

bind axi_mem_top axi_mem_chk u_chk (.*);

/* source/axi_mem_top.sv */
`timescale 1ns/100ps

module axi_mem_top
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,

  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready,

  input  axi_ar_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready
);

  mem_idx_t  rd_idx;
  mem_word_t rd_data;
  mem_wreq_t wreq;

  axi_mem_rd u_rd (
    .clk, .rstn,
    .ar, .ar_valid, .ar_ready,
    .r, .r_valid, .r_ready,
    .rd_idx, .rd_data
  );

  axi_mem_wr u_wr (
    .clk, .rstn,
    .aw, .aw_valid, .aw_ready,
    .w, .w_valid, .w_ready,
    .b, .b_valid, .b_ready,
    .wreq
  );

  mem_array u_mem (
    .clk,
    .rd_idx, .rd_data,
    .wreq
  );

endmodule

/* source/mem_array.sv */
`timescale 1ns/100ps

`include "axi_mem_cfg.svh"

module mem_array
  import mem_pkg::*;
(
  input  logic      clk,

  input  mem_idx_t  rd_idx,
  output mem_word_t rd_data,

  input  mem_wreq_t wreq
);

  mem_word_t mem [`MEM_DEPTH];

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  // Same-cycle write is not visible here yet
  assign rd_data = mem[rd_idx];

  // ------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wreq.en) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (wreq.strb[i]) begin
          mem[wreq.idx][i*8 +: 8] <= wreq.data[i*8 +: 8];  // One byte lane
        end
      end
    end
  end

endmodule

/* axi_mem/axi_mem_wr.sv */
`timescale 1ns/100ps

module axi_mem_wr
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,

  input  axi_ar_t   aw,
  input  logic      aw_valid,
  output logic      aw_ready,

  input  axi_w_t    w,
  input  logic      w_valid,
  output logic      w_ready,

  output axi_b_t    b,
  output logic      b_valid,
  input  logic      b_ready,

  output mem_wreq_t wreq
);

  logic      aw_held;  // Address waiting for its data
  logic      w_held;   // Data waiting for its address
  axi_addr_t addr_q;
  axi_data_t data_q;
  axi_strb_t strb_q;

  logic      b_pend;
  logic      aw_hs;
  logic      w_hs;
  logic      wr_fire;
  axi_addr_t addr_sel;

  // ------------------------------------------------------------
  // Pairing
  // ------------------------------------------------------------

  assign b_pend   = b_valid & ~b_ready;  // Response not yet taken
  assign aw_ready = ~aw_held & ~b_pend;
  assign w_ready  = ~w_held & ~b_pend;

  assign aw_hs    = aw_valid & aw_ready;
  assign w_hs     = w_valid & w_ready;
  assign wr_fire  = (aw_hs | aw_held) & (w_hs | w_held) & ~b_pend;
  assign addr_sel = aw_held ? addr_q : aw.addr;

  always_comb begin
    wreq.en   = wr_fire;
    wreq.idx  = addr_sel[IDX_LSB +: IDX_W];
    wreq.data = w_held ? data_q : w.data;
    wreq.strb = w_held ? strb_q : w.strb;
  end

  // ------------------------------------------------------------
  // Latches and response
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (aw_hs && !wr_fire) begin
        aw_held <= 1'b1;
        addr_q  <= aw.addr;
      end
      if (w_hs && !wr_fire) begin
        w_held <= 1'b1;
        data_q <= w.data;
        strb_q <= w.strb;
      end
      if (wr_fire) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        b_valid <= 1'b1;  // Wins over a same-cycle B handshake
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  assign b = '{resp: RESP_OKAY};

endmodule

/* axi_mem/axi_mem_rd.sv */
`timescale 1ns/100ps

module axi_mem_rd
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,

  input  axi_ar_t   ar,
  input  logic      ar_valid,
  output logic      ar_ready,

  output axi_r_t    r,
  output logic      r_valid,
  input  logic      r_ready,

  output mem_idx_t  rd_idx,
  input  mem_word_t rd_data
);

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  rd_state_e state;
  axi_ar_t   cur;       // Address of the beat on the bus
  axi_len_t  beat_cnt;  // Beats left after the current one
  axi_addr_t next_addr;
  axi_data_t r_data;
  logic      r_last;

  // ------------------------------------------------------------
  // Beat address
  // ------------------------------------------------------------

  axi_burst_addr u_burst_addr (
    .addr      (cur.addr),
    .size      (cur.size),
    .len       (cur.len),
    .burst     (cur.burst),
    .next_addr (next_addr)
  );

  always_comb begin
    if (state == RD_IDLE) begin
      rd_idx = ar.addr[IDX_LSB +: IDX_W];  // Beat 0 straight from AR
    end else begin
      rd_idx = next_addr[IDX_LSB +: IDX_W];
    end
  end

  // ------------------------------------------------------------
  // Burst control
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rstn) begin
      state    <= RD_IDLE;
      beat_cnt <= '0;
      r_last   <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_valid) begin
            state    <= RD_BURST;
            cur      <= ar;
            beat_cnt <= ar.len;
            r_data   <= rd_data;
            r_last   <= (ar.len == '0);
          end
        end
        RD_BURST: begin
          if (r_ready) begin
            if (r_last) begin
              state  <= RD_IDLE;
              r_last <= 1'b0;
            end else begin
              cur.addr <= next_addr;
              beat_cnt <= beat_cnt - 1'b1;
              r_data   <= rd_data;
              r_last   <= (beat_cnt == 8'd1);  // Counter hits zero
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  assign ar_ready = (state == RD_IDLE);
  assign r_valid  = (state == RD_BURST);
  assign r        = '{data: r_data, resp: RESP_OKAY, last: r_last};

endmodule

/* axi_mem/axi_burst_addr.sv */
`timescale 1ns/100ps

module axi_burst_addr
  import axi_pkg::*;
(
  input  axi_addr_t  addr,
  input  axi_size_t  size,
  input  axi_len_t   len,
  input  axi_burst_e burst,
  output axi_addr_t  next_addr
);

  logic [2:0] len_log2;
  logic [3:0] wrap_sh;
  axi_addr_t  incr_addr;
  axi_addr_t  wrap_mask;

  // Legal wrap lengths only, others give a zero-beat block
  always_comb begin
    case (len)
      8'd1:    len_log2 = 3'd1;
      8'd3:    len_log2 = 3'd2;
      8'd7:    len_log2 = 3'd3;
      8'd15:   len_log2 = 3'd4;
      default: len_log2 = 3'd0;
    endcase
  end

  assign wrap_sh   = {1'b0, size} + {1'b0, len_log2};
  assign incr_addr = addr + (axi_addr_t'(1) << size);
  assign wrap_mask = (axi_addr_t'(1) << wrap_sh) - axi_addr_t'(1);  // Bytes inside the block

  always_comb begin
    case (burst)
      BURST_INCR: next_addr = incr_addr;
      // With len_log2 zero the mask only covers bits below size, so addr is kept
      BURST_WRAP: next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:    next_addr = addr;
    endcase
  end

endmodule

/* common/mem_pkg.sv */
`include "axi_mem_cfg.svh"

package mem_pkg;

  localparam int unsigned IDX_W   = $clog2(`MEM_DEPTH);
  localparam int unsigned IDX_LSB = $clog2(`AXI_STRB_W);  // Byte offset bits in an address

  typedef logic [IDX_W-1:0]       mem_idx_t;
  typedef logic [`AXI_DATA_W-1:0] mem_word_t;

  // ------------------------------------------------------------
  // Write port request
  // ------------------------------------------------------------

  typedef struct packed {
    logic                   en;
    mem_idx_t               idx;
    mem_word_t              data;
    logic [`AXI_STRB_W-1:0] strb;
  } mem_wreq_t;

endpackage

/* common/axi_pkg.sv */
`include "axi_mem_cfg.svh"

package axi_pkg;

  // ------------------------------------------------------------
  // Field types
  // ------------------------------------------------------------

  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;
  typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [7:0]             axi_len_t;   // Beats minus one
  typedef logic [2:0]             axi_size_t;  // Log2 of bytes per beat
  typedef logic [1:0]             axi_resp_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // ------------------------------------------------------------
  // Channel payloads
  // ------------------------------------------------------------

  // Shared by AR and AW
  typedef struct packed {
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_e burst;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_t;

endpackage

/* common/axi_mem_cfg.svh */
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

// ------------------------------------------------------------
// Bus geometry
// ------------------------------------------------------------

`define AXI_ADDR_W 32  // Byte address
`define AXI_DATA_W 64
`define AXI_STRB_W 8   // One strobe per data byte

// ------------------------------------------------------------
// Backing store
// ------------------------------------------------------------

// Number of data-width words, power of two
`define MEM_DEPTH 4096

`endif
